// File: verilog.f
rtl/core_pkg.sv
rtl/stage_ifs.sv
rtl/instr_intake.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/pipe_core.sv
testbench/core_asserts.sv
testbench/core_checker.sv
testbench/tb_pipe_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module tb_pipe_core -f verilog.f
	-./obj_dir/Vtb_pipe_core > sim.log 2>&1
	@cat sim.log
	@if grep -q "Something failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_pipe_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_core;
    import core_pkg::*;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    word_t       instr;
    logic        result_valid;
    logic        result_ready;
    logic        result_write;
    reg_sel_t    result_sel;
    word_t       result_data;
    flags_t      flags;
    int          value_errors;
    int          flag_errors;
    int          protocol_errors;
    int          outstanding;
    logic        timed_out;
    logic [31:0] rng_state;

    pipe_core pipe_core_i (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_write (result_write),
        .result_sel   (result_sel),
        .result_data  (result_data),
        .flags        (flags)
    );

    // watches the same ports, owns the model
    core_checker checker_i (.*);

    bind pipe_core core_asserts asserts_i (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_write (result_write),
        .result_sel   (result_sel),
        .result_data  (result_data),
        .flags        (flags)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers

    // xorshift32, one shared stream in program order
    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t make_instr(input logic [4:0] op, input reg_sel_t rd,
                                         input reg_sel_t rs1, input reg_sel_t rs2,
                                         input logic [11:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // three picks in four land in r0..r7, so hazards come often
    function automatic reg_sel_t pick_reg(input logic [9:0] r);
        if (r[1:0] != 2'b00) begin
            return {2'b00, r[4:2]};
        end
        return r[9:5];
    endfunction

    task automatic note_timeout(input string why);
        $display("Timeout: %s", why);
        timed_out = 1'b1;
    endtask

    // result side back-pressure, ready three cycles in four
    task automatic drive_ready();
        logic [31:0] r;
        r = rand_next();
        result_ready <= |r[1:0];
    endtask

    // called at a rising edge, returns at the edge of the transfer
    task automatic send_instr(input word_t w);
        int   waited;
        logic accepted;
        if (timed_out) begin
            return;
        end
        instr_valid <= 1'b1;
        instr       <= w;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < 100) begin
            @(posedge clk);
            accepted = instr_ready;
            drive_ready();
            waited++;
        end
        if (!accepted) begin
            note_timeout("instruction not accepted within 100 cycles");
        end
    endtask

    task automatic idle_cycles(input int n);
        instr_valid <= 1'b0;
        repeat (n) begin
            @(posedge clk);
            drive_ready();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequences

    task automatic run_directed();
        // first read of every register, all zero
        for (int i = 1; i < reg_count; i++) begin
            send_instr(make_instr(op_add, reg_sel_t'(i), reg_sel_t'(i), 5'd0, 12'd0));
        end
        // negative immediate, then shifts by 31 and by 0
        send_instr(make_instr(op_addi, 5'd1, 5'd0, 5'd0, 12'hffb));
        send_instr(make_instr(op_addi, 5'd2, 5'd0, 5'd0, 12'd31));
        send_instr(make_instr(op_shl, 5'd3, 5'd1, 5'd2, 12'd0));
        send_instr(make_instr(op_shr, 5'd4, 5'd1, 5'd2, 12'd0));
        send_instr(make_instr(op_shr, 5'd5, 5'd1, 5'd0, 12'd0));
        // r6 used at distance 0, 1 and 2
        send_instr(make_instr(op_addi, 5'd6, 5'd1, 5'd0, 12'd9));
        send_instr(make_instr(op_sub, 5'd7, 5'd6, 5'd1, 12'd0));
        send_instr(make_instr(op_xor, 5'd8, 5'd6, 5'd7, 12'd0));
        send_instr(make_instr(op_or, 5'd9, 5'd6, 5'd8, 12'd0));
        send_instr(make_instr(op_cmp, 5'd10, 5'd9, 5'd9, 12'd0));
        // r0 target dropped, r0 still zero after
        send_instr(make_instr(op_addi, 5'd0, 5'd1, 5'd0, 12'd7));
        send_instr(make_instr(op_and, 5'd11, 5'd0, 5'd1, 12'd0));
        // undefined opcode
        send_instr(make_instr(5'd23, 5'd12, 5'd1, 5'd1, 12'd0));
    endtask

    task automatic run_random(input int count);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  opc;
        for (int i = 0; i < count; i++) begin
            r = rand_next();
            s = rand_next();
            // one in eight is a raw opcode, undefined ones included
            opc = (r[26:24] == 3'd0) ? r[31:27] : 5'(r[15:8] % 8'd10);
            send_instr(make_instr(opc, pick_reg(s[9:0]), pick_reg(s[19:10]),
                                  pick_reg(s[29:20]), r[11:0]));
            if (s[31:30] == 2'b00) begin
                idle_cycles(int'(r[23:22]) + 1);
            end
        end
    endtask

    initial begin
        int waited;
        rng_state    = 32'ha39f;
        timed_out    = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        result_ready = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        run_directed();
        run_random(400);
        // drain with back-pressure still running
        // one edge first so the count includes the last accepted word
        instr_valid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            drive_ready();
            waited++;
        end while (outstanding != 0 && waited < 500 && !timed_out);
        if (!timed_out && outstanding != 0) begin
            note_timeout("results still outstanding after 500 drain cycles");
        end
        // quiet tail, a stray result would show here
        result_ready <= 1'b1;
        repeat (8) @(posedge clk);
        $display("value errors %0d, flag errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, flag_errors, protocol_errors, timed_out);
        if (timed_out || (value_errors + flag_errors + protocol_errors != 0)) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module core_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_valid,
    input  logic               instr_ready,
    input  core_pkg::word_t    instr,
    input  logic               result_valid,
    input  logic               result_ready,
    input  logic               result_write,
    input  core_pkg::reg_sel_t result_sel,
    input  core_pkg::word_t    result_data,
    input  core_pkg::flags_t   flags,
    output int                 value_errors,
    output int                 flag_errors,
    output int                 protocol_errors,
    output int                 outstanding
);
    import core_pkg::*;

    // one expected retirement
    typedef struct packed {
        logic     write;
        reg_sel_t sel;
        word_t    data;
        flags_t   flags;
    } retire_t;

    word_t   model_regs [reg_count];
    flags_t  model_flags;
    retire_t expect_q [$];
    retire_t want;
    logic    was_reset;

    // architectural model, one instruction at a time in program order
    function automatic retire_t model_step(input word_t w);
        retire_t  r;
        reg_sel_t rd;
        word_t    a;
        word_t    b;
        word_t    res;
        logic     writes;
        logic     sets;
        rd     = w[rd_hi:rd_lo];
        a      = model_regs[w[rs1_hi:rs1_lo]];
        b      = model_regs[w[rs2_hi:rs2_lo]];
        res    = '0;
        writes = 1'b1;
        sets   = 1'b0;
        case (w[op_hi:op_lo])
            op_add:  res = a + b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_shl:  res = a << b[4:0];
            op_shr:  res = a >> b[4:0];
            op_addi: res = a + {{(xlen-imm_w){w[imm_hi]}}, w[imm_hi:imm_lo]};
            op_sub, op_cmp: begin
                res  = a - b;
                sets = 1'b1;
            end
            // undefined retires as nop
            default: writes = 1'b0;
        endcase
        if (rd == '0 || w[op_hi:op_lo] == op_cmp) begin
            writes = 1'b0;
        end
        if (sets) begin
            model_flags = {res[xlen-1], (res == '0)};
        end
        if (writes) begin
            model_regs[rd] = res;
        end
        r.write = writes;
        r.sel   = rd;
        r.data  = res;
        r.flags = model_flags;
        return r;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                model_regs[i] = '0;
            end
            model_flags = '0;
            expect_q.delete();
            value_errors    = 0;
            flag_errors     = 0;
            protocol_errors = 0;
            outstanding    <= 0;
        end else begin
            // port values right after reset
            if (was_reset && (result_valid !== 1'b0)) begin
                $display("Error result_valid: expected 0x0 got 0x%0h", result_valid);
                protocol_errors++;
            end
            if (was_reset && (instr_ready !== 1'b1)) begin
                $display("Error instr_ready: expected 0x1 got 0x%0h", instr_ready);
                protocol_errors++;
            end
            // pop before push, a result never belongs to this edge's instruction
            if (result_valid && result_ready) begin
                if (expect_q.size() == 0) begin
                    $display("Result retired while no instruction was outstanding");
                    protocol_errors++;
                end else begin
                    want = expect_q.pop_front();
                    if (result_write !== want.write) begin
                        $display("Error result_write: expected 0x%0h got 0x%0h",
                                 want.write, result_write);
                        value_errors++;
                    end
                    if (want.write && (result_sel !== want.sel)) begin
                        $display("Error result_sel: expected 0x%02h got 0x%02h",
                                 want.sel, result_sel);
                        value_errors++;
                    end
                    if (want.write && (result_data !== want.data)) begin
                        $display("Error result_data: expected 0x%08h got 0x%08h",
                                 want.data, result_data);
                        value_errors++;
                    end
                    if (flags !== want.flags) begin
                        $display("Error flags: expected 0x%0h got 0x%0h", want.flags, flags);
                        flag_errors++;
                    end
                end
            end
            if (instr_valid && instr_ready) begin
                expect_q.push_back(model_step(instr));
            end
            outstanding <= expect_q.size();
        end
        was_reset = reset;
    end

endmodule

`default_nettype wire

// File: testbench/core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module core_asserts (
    input logic               clk,
    input logic               reset,
    input logic               instr_valid,
    input logic               instr_ready,
    input logic               result_valid,
    input logic               result_ready,
    input logic               result_write,
    input core_pkg::reg_sel_t result_sel,
    input core_pkg::word_t    result_data,
    input core_pkg::flags_t   flags
);

    // intake open exactly when writeback is not held
    ready_tracks_stall: assert property (@(posedge clk) disable iff (reset)
        instr_ready == !(result_valid && !result_ready))
        else $error("instr_ready does not follow the result handshake");

    // held result keeps valid and payload
    result_held: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=>
            result_valid && $stable({result_write, result_sel, result_data, flags}))
        else $error("result port changed before it was taken");

    // accepted word plus three ready cycles, so it sits on the result port
    result_latency: assert property (@(posedge clk) disable iff (reset)
        $past(instr_valid && instr_ready, 4) && $past(result_ready, 3) &&
            $past(result_ready, 2) && $past(result_ready, 1) |-> result_valid)
        else $error("accepted instruction missed the result port after three free cycles");

endmodule

`default_nettype wire

// File: rtl/pipe_core.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_core (
    input  logic               clk,
    input  logic               reset,
    // instruction side
    input  logic               instr_valid,
    output logic               instr_ready,
    input  core_pkg::word_t    instr,
    // result side
    output logic               result_valid,
    input  logic               result_ready,
    output logic               result_write,
    output core_pkg::reg_sel_t result_sel,
    output core_pkg::word_t    result_data,
    output core_pkg::flags_t   flags
);
    import core_pkg::*;

    logic     fd_valid;
    word_t    fd_instr;
    logic     stall;
    logic     rf_write;
    reg_sel_t rf_sel;
    word_t    rf_data;

    de_ex_if de_ex ();
    ex_wb_if ex_wb ();

    ////////////////////////////////////////////////////////////////////////////
    // stages

    instr_intake intake_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .stall       (stall),
        .fd_valid    (fd_valid),
        .fd_instr    (fd_instr)
    );

    decode_stage decode_i (
        .clk      (clk),
        .reset    (reset),
        .fd_valid (fd_valid),
        .fd_instr (fd_instr),
        .stall    (stall),
        .rf_write (rf_write),
        .rf_sel   (rf_sel),
        .rf_data  (rf_data),
        .de_ex    (de_ex)
    );

    execute_stage execute_i (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .de_ex (de_ex),
        .ex_wb (ex_wb)
    );

    // stall and commit originate here
    writeback_stage writeback_i (
        .clk          (clk),
        .reset        (reset),
        .ex_wb        (ex_wb),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result_write (result_write),
        .result_sel   (result_sel),
        .result_data  (result_data),
        .flags        (flags),
        .stall        (stall),
        .rf_write     (rf_write),
        .rf_sel       (rf_sel),
        .rf_data      (rf_data)
    );

endmodule

`default_nettype wire

// File: rtl/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
    input  logic               clk,
    input  logic               reset,
    ex_wb_if.sink              ex_wb,
    input  logic               result_ready,
    output logic               result_valid,
    output logic               result_write,
    output core_pkg::reg_sel_t result_sel,
    output core_pkg::word_t    result_data,
    output core_pkg::flags_t   flags,
    output logic               stall,
    output logic               rf_write,
    output core_pkg::reg_sel_t rf_sel,
    output core_pkg::word_t    rf_data
);

    // result held but not taken, freeze everything
    assign stall = result_valid & ~result_ready;

    ////////////////////////////////////////////////////////////////////////////
    // register file commit

    // commit as the item moves into the result register, so an item
    // two behind sees it through the decode write-through
    assign rf_write = ex_wb.valid & ex_wb.reg_write & ~stall;
    assign rf_sel   = ex_wb.dest;
    assign rf_data  = ex_wb.data;

    ////////////////////////////////////////////////////////////////////////////
    // result register and flags

    // flags already include the item now on the result port
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result_write <= 1'b0;
            flags        <= '0;
        end else if (!stall) begin
            result_valid <= ex_wb.valid;
            result_write <= ex_wb.valid & ex_wb.reg_write;
            if (ex_wb.valid && ex_wb.flags_set) begin
                flags <= ex_wb.flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            result_sel  <= ex_wb.dest;
            result_data <= ex_wb.data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    de_ex_if.sink   de_ex,
    ex_wb_if.source ex_wb
);
    import core_pkg::*;

    logic  hit_a;
    logic  hit_b;
    word_t op_a;
    word_t fwd_b;
    word_t op_b;
    word_t diff;
    word_t result;
    logic  flags_set;

    ////////////////////////////////////////////////////////////////////////////
    // forwarding from the item one stage ahead

    // only a valid writing item counts, dest is never r0 then
    assign hit_a = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest == de_ex.rs1_sel);
    assign hit_b = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest == de_ex.rs2_sel);

    assign op_a  = hit_a ? ex_wb.data : de_ex.a;
    assign fwd_b = hit_b ? ex_wb.data : de_ex.b;

    // addi takes the immediate in place of rs2
    assign op_b  = de_ex.use_imm ? de_ex.imm : fwd_b;

    ////////////////////////////////////////////////////////////////////////////
    // alu

    // shared by sub, cmp and the flags
    assign diff = op_a - op_b;

    always_comb begin
        case (de_ex.op)
            op_add, op_addi: result = op_a + op_b;
            op_sub, op_cmp:  result = diff;
            op_and:          result = op_a & op_b;
            op_or:           result = op_a | op_b;
            op_xor:          result = op_a ^ op_b;
            // shift amount is the low 5 bits
            op_shl:          result = op_a << op_b[4:0];
            op_shr:          result = op_a >> op_b[4:0];
            default:         result = '0;
        endcase
    end

    assign flags_set = (de_ex.op == op_sub) || (de_ex.op == op_cmp);

    ////////////////////////////////////////////////////////////////////////////
    // execute to writeback register

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_wb.valid <= 1'b0;
        end else if (!stall) begin
            ex_wb.valid <= de_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_wb.reg_write <= de_ex.reg_write;
            ex_wb.dest      <= de_ex.dest;
            ex_wb.data      <= result;
            ex_wb.flags_set <= flags_set;
            // N from the sign, Z from an all-zero difference
            ex_wb.flags     <= {diff[xlen-1], (diff == '0)};
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fd_valid,
    input  core_pkg::word_t    fd_instr,
    input  logic               stall,
    input  logic               rf_write,
    input  core_pkg::reg_sel_t rf_sel,
    input  core_pkg::word_t    rf_data,
    de_ex_if.source            de_ex
);
    import core_pkg::*;

    word_t    regs [reg_count];
    op_e      op;
    reg_sel_t rd;
    reg_sel_t rs1;
    reg_sel_t rs2;
    word_t    imm_ext;
    word_t    rd_a;
    word_t    rd_b;
    logic     reg_write;

    // register read, r0 fixed at zero, same cycle commit bypassed
    function automatic word_t rf_read(input reg_sel_t sel);
        if (sel == '0) begin
            return '0;
        end
        if (rf_write && (rf_sel == sel)) begin
            return rf_data;
        end
        return regs[sel];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // field split

    assign rd  = fd_instr[rd_hi:rd_lo];
    assign rs1 = fd_instr[rs1_hi:rs1_lo];
    assign rs2 = fd_instr[rs2_hi:rs2_lo];
    assign imm_ext = {{(xlen-imm_w){fd_instr[imm_hi]}}, fd_instr[imm_hi:imm_lo]};

    // undefined opcodes fall back to nop
    always_comb begin
        case (fd_instr[op_hi:op_lo])
            op_add, op_sub, op_and, op_or, op_xor,
            op_shl, op_shr, op_addi, op_cmp: begin
                op = op_e'(fd_instr[op_hi:op_lo]);
            end
            default: begin
                op = op_nop;
            end
        endcase
    end

    // nop and cmp retire without a write, r0 never written
    assign reg_write = (op != op_nop) && (op != op_cmp) && (rd != '0);

    ////////////////////////////////////////////////////////////////////////////
    // register file

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write && (rf_sel != '0)) begin
            regs[rf_sel] <= rf_data;
        end
    end

    always_comb begin
        rd_a = rf_read(rs1);
        rd_b = rf_read(rs2);
    end

    ////////////////////////////////////////////////////////////////////////////
    // decode to execute register

    always_ff @(posedge clk) begin
        if (reset) begin
            de_ex.valid <= 1'b0;
        end else if (!stall) begin
            de_ex.valid <= fd_valid;
        end
    end

    // payload follows valid, held on stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            de_ex.op        <= op;
            de_ex.dest      <= rd;
            de_ex.reg_write <= reg_write;
            de_ex.rs1_sel   <= rs1;
            de_ex.rs2_sel   <= rs2;
            de_ex.a         <= rd_a;
            de_ex.b         <= rd_b;
            de_ex.use_imm   <= (op == op_addi);
            de_ex.imm       <= imm_ext;
        end
    end

endmodule

`default_nettype wire

// File: rtl/instr_intake.sv
`timescale 1ns/100ps
`default_nettype none

module instr_intake (
    input  logic            clk,
    input  logic            reset,
    input  logic            instr_valid,
    input  core_pkg::word_t instr,
    output logic            instr_ready,
    input  logic            stall,
    output logic            fd_valid,
    output core_pkg::word_t fd_instr
);

    // whole pipe freezes together, so intake follows the stall
    assign instr_ready = ~stall;

    ////////////////////////////////////////////////////////////////////////////
    // fetch to decode register

    // bubble in when nothing arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            fd_valid <= 1'b0;
        end else if (!stall) begin
            fd_valid <= instr_valid;
        end
    end

    // word only loads on an accepted transfer
    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            fd_instr <= instr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/stage_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// decode to execute item
interface de_ex_if;
    import core_pkg::*;

    logic     valid;
    op_e      op;
    reg_sel_t dest;
    logic     reg_write;
    // source selects, kept for forwarding
    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;
    word_t    a;
    word_t    b;
    logic     use_imm;
    // already sign extended
    word_t    imm;

    modport source (output valid, op, dest, reg_write, rs1_sel, rs2_sel, a, b, use_imm, imm);
    modport sink   (input  valid, op, dest, reg_write, rs1_sel, rs2_sel, a, b, use_imm, imm);
endinterface

// execute to writeback item
interface ex_wb_if;
    import core_pkg::*;

    logic     valid;
    logic     reg_write;
    reg_sel_t dest;
    word_t    data;
    // sub and cmp only
    logic     flags_set;
    flags_t   flags;

    modport source (output valid, reg_write, dest, data, flags_set, flags);
    modport sink   (input  valid, reg_write, dest, data, flags_set, flags);
endinterface

`default_nettype wire

// File: rtl/core_pkg.sv
`default_nettype none

package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes

    // data and instruction width
    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_sel_w = 5;
    localparam int imm_w     = 12;
    localparam int opcode_w  = 5;

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    // layout: op | rd | rs1 | rs2 | imm

    localparam int op_hi  = 31;
    localparam int op_lo  = 27;
    localparam int rd_hi  = 26;
    localparam int rd_lo  = 22;
    localparam int rs1_hi = 21;
    localparam int rs1_lo = 17;
    localparam int rs2_hi = 16;
    localparam int rs2_lo = 12;
    localparam int imm_hi = 11;
    localparam int imm_lo = 0;

    ////////////////////////////////////////////////////////////////////////////
    // types

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_sel_w-1:0] reg_sel_t;

    // N in bit 1, Z in bit 0
    typedef logic [1:0]           flags_t;

    // opcodes, anything outside this list decodes as nop
    typedef enum logic [opcode_w-1:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_and  = 5'd3,
        op_or   = 5'd4,
        op_xor  = 5'd5,
        op_shl  = 5'd6,
        op_shr  = 5'd7,
        op_addi = 5'd8,
        op_cmp  = 5'd9
    } op_e;

endpackage

`default_nettype wire
